// ==== rtl/sdramPkg.sv ====
// ==============================
// SDRAM device package
// Bank, row and column widths
// Timing in clock cycles and the command enum
// ==============================
package sdramPkg;

    // ==============================
    // Geometry
    // ==============================
    localparam int bankBits = 2;        // Four banks
    localparam int rowBits  = 12;       // Also the address pin width
    localparam int colBits  = 8;        // 256 words per row

    // ==============================
    // Timing
    // ==============================
    localparam int casLatency = 2;      // READ to data on dqRead
    localparam int tRcd       = 2;      // ACTIVE to first READ/WRITE
    localparam int tWr        = 2;      // Last WRITE to PRECHARGE
    localparam int tRp        = 2;      // PRECHARGE to bank idle

    // Encoded as {RAS_N, CAS_N, WE_N}
    typedef enum logic [2:0] {
        cmdNop       = 3'b111,
        cmdActive    = 3'b011,
        cmdRead      = 3'b101,
        cmdWrite     = 3'b100,
        cmdPrecharge = 3'b010
    } sdramCmdT;

endpackage

// ==== rtl/ctrlPkg.sv ====
// ==============================
// Controller package
// Word, address, length and level types
// Sequencer state enum
// ==============================
package ctrlPkg;

    localparam int dataBits  = 16;
    localparam int addrBits  = 22;      // Bank, row, column from the top
    localparam int fifoDepth = 16;

    typedef logic [dataBits-1:0]          dataT;
    typedef logic [addrBits-1:0]          addrT;
    typedef logic [7:0]                   lenT;     // Burst length in words
    typedef logic [$clog2(fifoDepth):0]   levelT;   // Holds 0 to fifoDepth

    // Burst sequencer
    typedef enum logic [2:0] {
        seqIdle,                        // Waiting for burstStart
        seqActivate,                    // Row open, counting tRcd
        seqTransfer,                    // One READ/WRITE per cycle
        seqRecover,                     // Write recovery or read data drain
        seqPrecharge                    // Counting tRp
    } seqStateT;

endpackage

// ==== rtl/burstFifo.sv ====
// ==============================
// Synchronous FIFO
// First word fall through
// Single cycle clear and fill level
// ==============================
`timescale 1ns/10ps

module burstFifo #(
    parameter int depth = ctrlPkg::fifoDepth
) (
    input  logic           CLK,
    input  logic           RESET_N,
    input  logic           clear,
    input  logic           push,
    input  ctrlPkg::dataT  pushData,
    input  logic           pop,
    output ctrlPkg::dataT  headData,
    output ctrlPkg::levelT level,
    output logic           full,
    output logic           empty
);
    import ctrlPkg::*;

    dataT                       mem [depth];
    logic [$clog2(depth)-1:0]   wrPtr;
    logic [$clog2(depth)-1:0]   rdPtr;
    logic                       doPush;
    logic                       doPop;

    assign full     = (level == levelT'(depth));
    assign empty    = (level == '0);
    assign doPush   = push && !full;    // Overflowing push dropped
    assign doPop    = pop && !empty;    // Underflowing pop dropped
    assign headData = mem[rdPtr];       // Head visible without a pop

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end
        else if (clear)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= (int'(wrPtr) == depth - 1) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (int'(rdPtr) == depth - 1) ? '0 : rdPtr + 1'b1;
            if (doPush && !doPop)
                level <= level + 1'b1;
            else if (doPop && !doPush)
                level <= level - 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    // Producer side must respect full
    pushWhenFull: assert property (@(posedge CLK) disable iff (!RESET_N)
        push && !clear |-> !full)
        else $error("push arrived while the FIFO was full");

    // Consumer side must respect empty
    popWhenEmpty: assert property (@(posedge CLK) disable iff (!RESET_N)
        pop && !clear |-> !empty)
        else $error("pop arrived while the FIFO was empty");

endmodule

// ==== rtl/portScheduler.sv ====
// ==============================
// Port scheduler
// Current address per port and window wrap
// Picks the next burst with writes first
// ==============================
`timescale 1ns/10ps

module portScheduler (
    input  logic           CLK,
    input  logic           RESET_N,
    input  logic           writeLoad,
    input  ctrlPkg::addrT  writeStart,
    input  ctrlPkg::addrT  writeMax,
    input  ctrlPkg::lenT   writeLength,
    input  ctrlPkg::levelT writeLevel,
    input  logic           readLoad,
    input  ctrlPkg::addrT  readStart,
    input  ctrlPkg::addrT  readMax,
    input  ctrlPkg::lenT   readLength,
    input  ctrlPkg::levelT readLevel,
    output logic           burstStart,
    output logic           burstWrite,
    output ctrlPkg::addrT  burstAddr,
    output ctrlPkg::lenT   burstLength,
    input  logic           burstDone
);
    import ctrlPkg::*;

    addrT writeAddr;                    // Next write burst address
    addrT readAddr;                     // Next read burst address
    logic busy;                         // Burst outstanding
    logic writeReady;
    logic readReady;
    logic startNow;

    // Step by one burst or fall back to the window start
    function automatic addrT nextAddr(addrT cur, addrT start, addrT max, lenT len);
        if (cur < max - addrT'(len))
            return cur + addrT'(len);
        return start;
    endfunction

    // Write FIFO holds a whole burst
    assign writeReady = (writeLength != '0) && (writeLevel >= writeLength);
    // Read FIFO has room for a whole burst
    assign readReady  = (readLength != '0) && (readLevel < readLength);
    assign startNow   = !busy && !writeLoad && !readLoad && (writeReady || readReady);

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            busy       <= 1'b0;
            burstStart <= 1'b0;
            burstWrite <= 1'b0;
            writeAddr  <= '0;
            readAddr   <= '0;
        end
        else
        begin
            burstStart <= startNow;     // One cycle pulse
            if (startNow)
            begin
                busy       <= 1'b1;
                burstWrite <= writeReady;   // Write wins a tie
            end
            else if (burstDone)
                busy <= 1'b0;

            if (writeLoad)
                writeAddr <= writeStart;
            else if (burstDone && burstWrite)
                writeAddr <= nextAddr(writeAddr, writeStart, writeMax, writeLength);

            if (readLoad)
                readAddr <= readStart;
            else if (burstDone && !burstWrite)
                readAddr <= nextAddr(readAddr, readStart, readMax, readLength);
        end
    end

    // Request payload held until the next start
    always_ff @(posedge CLK)
    begin
        if (startNow)
        begin
            burstAddr   <= writeReady ? writeAddr : readAddr;
            burstLength <= writeReady ? writeLength : readLength;
        end
    end

endmodule

// ==== rtl/burstSequencer.sv ====
// ==============================
// Burst sequencer
// ACTIVE, READ/WRITE per word, PRECHARGE
// Write data out and read data capture
// ==============================
`timescale 1ns/10ps

module burstSequencer (
    input  logic                          CLK,
    input  logic                          RESET_N,
    input  logic                          burstStart,
    input  logic                          burstWrite,
    input  ctrlPkg::addrT                 burstAddr,
    input  ctrlPkg::lenT                  burstLength,
    output logic                          burstDone,
    output logic                          dataPop,
    input  ctrlPkg::dataT                 headData,
    output logic                          dataPush,
    output ctrlPkg::dataT                 pushData,
    output sdramPkg::sdramCmdT            sdramCmd,
    output logic [sdramPkg::bankBits-1:0] sdramBank,
    output logic [sdramPkg::rowBits-1:0]  sdramAddr,
    output ctrlPkg::dataT                 dqWrite,
    input  ctrlPkg::dataT                 dqRead,
    output logic                          dqDrive
);
    import ctrlPkg::*;
    import sdramPkg::*;

    seqStateT                   state;
    lenT                        cnt;        // Cycles left in the current state
    logic [colBits-1:0]         col;        // Column of the next access
    logic [casLatency-1:0]      readPipe;   // READ commands in flight

    // FIFO head leaves in the cycle before its WRITE shows on the pins
    assign dataPop = (state == seqTransfer) && burstWrite;

    // ==============================
    // FSM and pin commands
    // ==============================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            state     <= seqIdle;
            cnt       <= '0;
            sdramCmd  <= cmdNop;
            dqDrive   <= 1'b0;
            burstDone <= 1'b0;
            readPipe  <= '0;
            dataPush  <= 1'b0;
        end
        else
        begin
            sdramCmd  <= cmdNop;        // Default between commands
            dqDrive   <= 1'b0;
            burstDone <= 1'b0;
            readPipe  <= {readPipe[casLatency-2:0], sdramCmd == cmdRead};
            dataPush  <= readPipe[casLatency-1];    // Data due at this edge
            case (state)
                seqIdle:
                    if (burstStart)
                    begin
                        sdramCmd <= cmdActive;
                        cnt      <= lenT'(tRcd - 2);
                        state    <= seqActivate;
                    end
                seqActivate:
                    if (cnt == '0)
                    begin
                        cnt   <= burstLength - 1'b1;
                        state <= seqTransfer;
                    end
                    else
                        cnt <= cnt - 1'b1;
                seqTransfer:
                begin
                    sdramCmd <= burstWrite ? cmdWrite : cmdRead;
                    dqDrive  <= burstWrite;             // Only in WRITE cycles
                    if (cnt == '0)
                    begin
                        // Reads wait for the last word to come back
                        cnt   <= burstWrite ? lenT'(tWr - 1) : lenT'(casLatency);
                        state <= seqRecover;
                    end
                    else
                        cnt <= cnt - 1'b1;
                end
                seqRecover:
                    if (cnt == '0)
                    begin
                        sdramCmd <= cmdPrecharge;
                        cnt      <= lenT'(tRp - 1);
                        state    <= seqPrecharge;
                    end
                    else
                        cnt <= cnt - 1'b1;
                seqPrecharge:
                    if (cnt == '0)
                    begin
                        burstDone <= 1'b1;  // Lands tRp after PRECHARGE
                        state     <= seqIdle;
                    end
                    else
                        cnt <= cnt - 1'b1;
                default:
                    state <= seqIdle;
            endcase
        end
    end

    // ==============================
    // Address and data payload
    // ==============================
    always_ff @(posedge CLK)
    begin
        pushData <= dqRead;     // Sampled every edge and qualified by dataPush
        if (state == seqIdle && burstStart)
        begin
            sdramBank <= burstAddr[addrBits-1 -: bankBits];
            sdramAddr <= burstAddr[colBits +: rowBits];     // Row for ACTIVE
            col       <= burstAddr[colBits-1:0];
        end
        else if (state == seqTransfer)
        begin
            sdramAddr <= {{(rowBits - colBits){1'b0}}, col};   // A10 low
            col       <= col + 1'b1;
            if (burstWrite)
                dqWrite <= headData;
        end
        else if (state == seqRecover && cnt == '0)
            sdramAddr <= '0;    // A10 low closes this bank only
    end

    // Scheduler keeps one burst in flight
    startOnlyIdle: assert property (@(posedge CLK) disable iff (!RESET_N)
        burstStart |-> state == seqIdle)
        else $error("burstStart arrived while a burst was still running");

    activeToAccess: assert property (@(posedge CLK) disable iff (!RESET_N)
        sdramCmd == cmdActive |-> ##tRcd (sdramCmd inside {cmdRead, cmdWrite}))
        else $error("first READ or WRITE did not follow ACTIVE after tRcd cycles");

endmodule

// ==== rtl/sdramController.sv ====
// ==============================
// SDRAM burst controller top
// Write and read FIFOs, scheduler, sequencer
// ==============================
`timescale 1ns/10ps

module sdramController (
    input  logic                          CLK,
    input  logic                          RESET_N,
    // Write port
    input  ctrlPkg::dataT                 writeData,
    input  logic                          writeStrobe,
    output logic                          writeFull,
    input  logic                          writeLoad,      // Clears FIFO and address
    input  ctrlPkg::addrT                 writeStart,
    input  ctrlPkg::addrT                 writeMax,
    input  ctrlPkg::lenT                  writeLength,
    // Read port
    output ctrlPkg::dataT                 readData,
    input  logic                          readStrobe,
    output logic                          readEmpty,
    input  logic                          readLoad,
    input  ctrlPkg::addrT                 readStart,
    input  ctrlPkg::addrT                 readMax,
    input  ctrlPkg::lenT                  readLength,
    // SDRAM pins
    output logic                          csN,
    output logic                          rasN,
    output logic                          casN,
    output logic                          weN,
    output logic [sdramPkg::bankBits-1:0] sdramBank,
    output logic [sdramPkg::rowBits-1:0]  sdramAddr,
    output ctrlPkg::dataT                 dqWrite,
    input  ctrlPkg::dataT                 dqRead,
    output logic                          dqDrive
);
    import ctrlPkg::*;
    import sdramPkg::*;

    levelT    writeLevel;
    levelT    readLevel;
    dataT     writeHead;                // Next word for the SDRAM
    dataT     pushData;                 // Word returned by the SDRAM
    logic     dataPop;
    logic     dataPush;
    logic     burstStart;
    logic     burstWrite;
    logic     burstDone;
    addrT     burstAddr;
    lenT      burstLength;
    sdramCmdT sdramCmd;

    assign csN                = 1'b0;   // Single device always selected
    assign {rasN, casN, weN}  = sdramCmd;

    burstFifo i_writeFifo (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .clear    (writeLoad),
        .push     (writeStrobe),
        .pushData (writeData),
        .pop      (dataPop),
        .headData (writeHead),
        .level    (writeLevel),
        .full     (writeFull),
        .empty    ()
    );

    burstFifo i_readFifo (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .clear    (readLoad),
        .push     (dataPush),
        .pushData (pushData),
        .pop      (readStrobe),
        .headData (readData),
        .level    (readLevel),
        .full     (),
        .empty    (readEmpty)
    );

    portScheduler i_portScheduler (
        .CLK         (CLK),
        .RESET_N     (RESET_N),
        .writeLoad   (writeLoad),
        .writeStart  (writeStart),
        .writeMax    (writeMax),
        .writeLength (writeLength),
        .writeLevel  (writeLevel),
        .readLoad    (readLoad),
        .readStart   (readStart),
        .readMax     (readMax),
        .readLength  (readLength),
        .readLevel   (readLevel),
        .burstStart  (burstStart),
        .burstWrite  (burstWrite),
        .burstAddr   (burstAddr),
        .burstLength (burstLength),
        .burstDone   (burstDone)
    );

    burstSequencer i_burstSequencer (
        .CLK         (CLK),
        .RESET_N     (RESET_N),
        .burstStart  (burstStart),
        .burstWrite  (burstWrite),
        .burstAddr   (burstAddr),
        .burstLength (burstLength),
        .burstDone   (burstDone),
        .dataPop     (dataPop),
        .headData    (writeHead),
        .dataPush    (dataPush),
        .pushData    (pushData),
        .sdramCmd    (sdramCmd),
        .sdramBank   (sdramBank),
        .sdramAddr   (sdramAddr),
        .dqWrite     (dqWrite),
        .dqRead      (dqRead),
        .dqDrive     (dqDrive)
    );

endmodule

// ==== tb/sdramModel.sv ====
// ==============================
// Behavioral SDRAM
// Command decode, open row per bank
// Word store and CAS latency read path
// ==============================
`timescale 1ns/10ps

module sdramModel (
    input  logic                          CLK,
    input  logic                          csN,
    input  logic                          rasN,
    input  logic                          casN,
    input  logic                          weN,
    input  logic [sdramPkg::bankBits-1:0] bank,
    input  logic [sdramPkg::rowBits-1:0]  addr,
    input  ctrlPkg::dataT                 dqWrite,
    output ctrlPkg::dataT                 dqRead
);
    import ctrlPkg::*;
    import sdramPkg::*;

    localparam int memWords = 4096;     // Covers both test windows

    dataT                 mem [memWords];
    logic [rowBits-1:0]   openRow [1 << bankBits];
    dataT                 readPipe [casLatency];
    logic [2:0]           cmd;
    addrT                 linear;
    int                   errors;

    assign cmd    = {rasN, casN, weN};
    assign linear = {bank, openRow[bank], addr[colBits-1:0]};
    assign dqRead = readPipe[casLatency-1];     // Data lands casLatency edges later

    // Every word starts as the low bits of its own address
    initial
    begin
        errors = 0;
        for (int i = 0; i < memWords; i++)
            mem[i] <= dataT'(i);
        for (int i = 0; i < casLatency; i++)
            readPipe[i] <= '0;
    end

    always @(posedge CLK)
    begin
        for (int i = casLatency - 1; i > 0; i--)
            readPipe[i] <= readPipe[i-1];
        readPipe[0] <= '0;
        if (!csN)
        begin
            if (cmd == cmdActive)
                openRow[bank] <= addr;
            else if (cmd == cmdRead || cmd == cmdWrite)
            begin
                if (linear >= addrT'(memWords))
                begin
                    $display("SDRAM model access outside its memory at %h", linear);
                    errors++;
                end
                else if (cmd == cmdWrite)
                    mem[linear[11:0]] <= dqWrite;
                else
                    readPipe[0] <= mem[linear[11:0]];   // First stage of CAS delay
            end
        end
    end

endmodule

// ==== tb/tbSdramController.sv ====
// ==============================
// Testbench for the SDRAM burst controller
// Clock, reset, port stimulus, pin monitor
// Assertions check data and command protocol
// ==============================
`timescale 1ns/10ps

module tbSdramController;
    import ctrlPkg::*;
    import sdramPkg::*;

    localparam int   waitLimit  = 2000;     // Cycles per wait loop
    localparam addrT writeBase  = 22'd0;
    localparam addrT writeTop   = 22'd64;
    localparam addrT readBase   = 22'd1024;
    localparam addrT readTop    = 22'd1056;

    logic CLK = 1'b0;
    logic RESET_N;
    dataT writeData;
    logic writeStrobe, writeFull, writeLoad;
    dataT readData;
    logic readStrobe, readEmpty, readLoad;
    logic csN, rasN, casN, weN, dqDrive;
    logic [bankBits-1:0] sdramBank;
    logic [rowBits-1:0]  sdramAddr;
    dataT dqWrite, dqRead;
    logic [2:0] pinCmd;

    integer seed = 80486;
    int     errorCount = 0;
    int     testsPassed = 0;
    int     testsFailed = 0;
    int     activeCount = 0;
    int     prechargeCount = 0;
    int     writeCmdCount = 0;
    logic   openBurst;
    logic   quietPhase = 1'b0;
    logic [bankBits-1:0] lastBank;
    logic [rowBits-1:0]  lastRow;
    dataT   writeRef [$];

    always #50 CLK = ~CLK;
    assign pinCmd = {rasN, casN, weN};

    sdramController i_dut (
        .CLK (CLK), .RESET_N (RESET_N),
        .writeData (writeData), .writeStrobe (writeStrobe), .writeFull (writeFull),
        .writeLoad (writeLoad), .writeStart (writeBase), .writeMax (writeTop),
        .writeLength (8'd8),
        .readData (readData), .readStrobe (readStrobe), .readEmpty (readEmpty),
        .readLoad (readLoad), .readStart (readBase), .readMax (readTop),
        .readLength (8'd8),
        .csN (csN), .rasN (rasN), .casN (casN), .weN (weN),
        .sdramBank (sdramBank), .sdramAddr (sdramAddr),
        .dqWrite (dqWrite), .dqRead (dqRead), .dqDrive (dqDrive)
    );

    sdramModel i_model (
        .CLK (CLK), .csN (csN), .rasN (rasN), .casN (casN), .weN (weN),
        .bank (sdramBank), .addr (sdramAddr), .dqWrite (dqWrite), .dqRead (dqRead)
    );

    // Pin monitor
    always @(posedge CLK)
    begin
        if (!RESET_N)
            openBurst <= 1'b0;
        if (pinCmd == cmdActive)
        begin
            activeCount++;
            openBurst <= 1'b1;
            lastBank  <= sdramBank;
            lastRow   <= sdramAddr;
        end
        if (pinCmd == cmdPrecharge)
        begin
            prechargeCount++;
            openBurst <= 1'b0;
        end
        if (pinCmd == cmdWrite)
            writeCmdCount++;
    end

    // ==============================
    // Protocol assertions
    // ==============================
    quietPins: assert property (@(posedge CLK) disable iff (!RESET_N)
        quietPhase |-> (pinCmd == cmdNop && !dqDrive && readEmpty))
        else
        begin
            $display("Pins were not quiet before the first burst");
            errorCount++;
        end

    driveOnWrite: assert property (@(posedge CLK) disable iff (!RESET_N)
        dqDrive |-> pinCmd == cmdWrite)
        else
        begin
            $display("dqDrive was high outside a WRITE cycle");
            errorCount++;
        end

    rcdSpacing: assert property (@(posedge CLK) disable iff (!RESET_N)
        pinCmd == cmdActive |-> ##tRcd (pinCmd == cmdRead || pinCmd == cmdWrite))
        else
        begin
            $display("ACTIVE was not followed by an access after tRcd");
            errorCount++;
        end

    activeWhenClosed: assert property (@(posedge CLK) disable iff (!RESET_N)
        pinCmd == cmdActive |-> !openBurst)
        else
        begin
            $display("ACTIVE came before the previous PRECHARGE");
            errorCount++;
        end

    prechargeWhenOpen: assert property (@(posedge CLK) disable iff (!RESET_N)
        pinCmd == cmdPrecharge |-> openBurst)
        else
        begin
            $display("PRECHARGE came without an open burst");
            errorCount++;
        end

    // ==============================
    // Helpers
    // ==============================
    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp)
        else
        begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic reportTimeout(string what);
        $display("Timeout while waiting for %s", what);
        errorCount++;
    endtask

    task automatic nextCycle();
        @(posedge CLK);
        #1;     // Drive and sample clear of the edge
    endtask

    task automatic pushWord(dataT word);
        int n;
        n = 0;
        while (writeFull && n < waitLimit)
        begin
            nextCycle();
            n++;
        end
        if (writeFull)
            reportTimeout("room in the write FIFO");
        else
        begin
            writeData   = word;
            writeStrobe = 1'b1;
            nextCycle();
            writeStrobe = 1'b0;
        end
    endtask

    task automatic popAndCheck(dataT expected);
        int n;
        n = 0;
        while (readEmpty && n < waitLimit)
        begin
            nextCycle();
            n++;
        end
        if (readEmpty)
            reportTimeout("read data");
        else
        begin
            checkValue("readData", 32'(readData), 32'(expected));
            readStrobe = 1'b1;
            nextCycle();
            readStrobe = 1'b0;
        end
    endtask

    task automatic waitWrites(int target);
        int n;
        n = 0;
        while (writeCmdCount < target && n < waitLimit)
        begin
            nextCycle();
            n++;
        end
        if (writeCmdCount < target)
            reportTimeout("WRITE commands");
    endtask

    // Ten closed cycles in a row means no burst is running
    task automatic waitIdle();
        int n;
        int calm;
        n = 0;
        calm = 0;
        while (calm < 10 && n < waitLimit)
        begin
            nextCycle();
            calm = openBurst ? 0 : calm + 1;
            n++;
        end
        if (calm < 10)
            reportTimeout("the controller to go idle");
    endtask

    task automatic finishTest(string name, int errorsBefore);
        if (errorCount == errorsBefore)
        begin
            $display("Test %s: pass", name);
            testsPassed++;
        end
        else
        begin
            $display("Test %s: fail", name);
            testsFailed++;
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial
    begin
        int mark;
        int n;
        dataT fresh [$];
        RESET_N     = 1'b0;
        writeData   = '0;
        writeStrobe = 1'b0;
        writeLoad   = 1'b0;
        readStrobe  = 1'b0;
        readLoad    = 1'b1;     // Read port parked until test 2
        repeat (8) @(posedge CLK);
        #1 RESET_N = 1'b1;

        // Test 1 with fewer than a burst of words
        mark = errorCount;
        quietPhase = 1'b1;
        for (int i = 0; i < 7; i++)
        begin
            writeRef.push_back(dataT'($random(seed)));
            pushWord(writeRef[i]);
        end
        repeat (20) nextCycle();
        quietPhase = 1'b0;
        checkValue("activeCount", 32'(activeCount), 32'd0);
        finishTest("1 idle pins", mark);

        // Test 2 fills the whole write window
        mark = errorCount;
        readLoad = 1'b0;    // Any load holds off every burst
        for (int i = 7; i < 64; i++)
        begin
            writeRef.push_back(dataT'($random(seed)));
            pushWord(writeRef[i]);
        end
        waitWrites(64);
        waitIdle();
        for (int i = 0; i < 64; i++)
            checkValue($sformatf("mem[%0d]", i), 32'(i_model.mem[i]), 32'(writeRef[i]));
        finishTest("2 write order", mark);

        // Test 3 reads one full window
        mark = errorCount;
        for (int i = 0; i < 32; i++)
            popAndCheck(dataT'(int'(readBase) + i));
        finishTest("3 read order", mark);

        // Test 4 wraps both windows
        mark = errorCount;
        for (int i = 0; i < 8; i++)
            popAndCheck(dataT'(int'(readBase) + i));
        for (int i = 0; i < 8; i++)
        begin
            fresh.push_back(dataT'($random(seed)));
            pushWord(fresh[i]);
        end
        waitWrites(72);
        waitIdle();
        for (int i = 0; i < 8; i++)
            checkValue($sformatf("mem[%0d]", i), 32'(i_model.mem[i]), 32'(fresh[i]));
        finishTest("4 window wrap", mark);

        // Test 5 load strobe and write priority
        mark = errorCount;
        readLoad = 1'b1;
        waitIdle();
        for (int i = 0; i < fifoDepth; i++)
            pushWord(dataT'($random(seed)));
        checkValue("writeFull", 32'(writeFull), 32'd1);
        writeLoad = 1'b1;
        nextCycle();
        writeLoad = 1'b0;
        checkValue("writeFull", 32'(writeFull), 32'd0);
        fresh.delete();
        for (int i = 0; i < 8; i++)
        begin
            fresh.push_back(dataT'($random(seed)));
            pushWord(fresh[i]);
        end
        n = activeCount;
        readLoad = 1'b0;    // Both ports ready from here on
        waitWrites(80);
        checkValue("activeCount", 32'(activeCount), 32'(n + 1));
        checkValue("lastBank", 32'(lastBank), 32'd0);
        checkValue("lastRow", 32'(lastRow), 32'd0);
        waitIdle();
        for (int i = 0; i < 8; i++)
            checkValue($sformatf("mem[%0d]", i), 32'(i_model.mem[i]), 32'(fresh[i]));
        finishTest("5 load and priority", mark);

        // Test 6 counts commands over the whole run
        mark = errorCount;
        checkValue("prechargeCount", 32'(prechargeCount), 32'(activeCount));
        checkValue("modelErrors", 32'(i_model.errors), 32'd0);
        finishTest("6 command protocol", mark);

        $display("Tests passed %0d, failed %0d, errors %0d",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== sdramController.f ====
rtl/sdramPkg.sv
rtl/ctrlPkg.sv
rtl/burstFifo.sv
rtl/portScheduler.sv
rtl/burstSequencer.sv
rtl/sdramController.sv
tb/sdramModel.sv
tb/tbSdramController.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SDRAM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f sdramController.f \
    --top-module tbSdramController \
    --Mdir obj_dir -o tbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
